//--- bench/execTb.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module execTb;

    localparam int maxCycles = 4000;  // about ten times the length of all tests
    localparam int grantNone = 0;
    localparam int grantFree = 1;
    localparam int grantRandom = 2;

    logic              clk = 1'b0;
    logic              rstN;
    logic              inValid;
    execPkg::execReqT  inReq;
    logic              inCredit;
    logic              outValid;
    execPkg::execRespT outResp;
    logic              outCredit;

    execPkg::execRespT expQ [$];     // expected responses in send order
    execPkg::execRespT expHead;
    logic [`EXEC_TAG_W-1:0] tagSeq;
    int seed;
    int grantSeed;
    int grantRnd;
    int credits;          // producer side
    int outCredits;       // granted to the DUT and not yet used
    int grantMode;
    int manualGrants;
    int resultsSeen;
    int cycles;
    int errors;
    int errAtStart;
    int passCount;
    int failCount;

    execTop dut (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReq     (inReq),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outResp   (outResp),
        .outCredit (outCredit)
    );

    always #2 clk = ~clk;

    function automatic execPkg::execRespT refModel(input execPkg::execReqT r);
        logic [`EXEC_XLEN-1:0] a;
        logic [`EXEC_XLEN-1:0] b;
        execPkg::execRespT e;
        a = (r.srcA == execPkg::srcAReg) ? r.rs1Data :
            (r.srcA == execPkg::srcAZero) ? '0 : r.pc;
        b = (r.srcB == execPkg::srcBReg) ? r.rs2Data :
            (r.srcB == execPkg::srcBImm) ? r.imm : `EXEC_XLEN'(4);
        e.target = ((r.pcBase == execPkg::pcBaseReg) ? r.rs1Data : r.pc) + r.imm;
        e.tag = r.tag;
        e.taken = 1'b0;
        e.isBranch = 1'b0;
        if (r.aluOp == execPkg::aluOpAddr) begin
            e.result = a + b;
        end else if (r.aluOp == execPkg::aluOpBranch) begin
            e.result = a - b;
            e.isBranch = 1'b1;
            case (r.funct3)
                3'd0: e.taken = (a == b);
                3'd1: e.taken = (a != b);
                3'd4: e.taken = ($signed(a) < $signed(b));
                3'd5: e.taken = ($signed(a) >= $signed(b));
                3'd6: e.taken = (a < b);
                3'd7: e.taken = (a >= b);
                default: e.isBranch = 1'b0;  // reserved encodings
            endcase
        end else begin
            case (r.funct3)
                3'd0: e.result = (r.aluOp == execPkg::aluOpR && r.funct7 == 7'h20) ? a - b : a + b;
                3'd1: e.result = a << b[4:0];
                3'd2: e.result = `EXEC_XLEN'($signed(a) < $signed(b));
                3'd3: e.result = `EXEC_XLEN'(a < b);
                3'd4: e.result = a ^ b;
                3'd5: e.result = (r.funct7 == 7'h20) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: e.result = a | b;
                default: e.result = a & b;
            endcase
        end
        return e;
    endfunction

    function automatic execPkg::execReqT mkReq(input execPkg::aluOpE op, input logic [2:0] f3,
            input logic [6:0] f7, input execPkg::srcAE sa, input execPkg::srcBE sb,
            input execPkg::pcBaseE base, input logic [31:0] pc, input logic [31:0] rs1,
            input logic [31:0] rs2, input logic [31:0] imm);
        execPkg::execReqT r;
        r = '0;
        r.aluOp = op;
        r.funct3 = f3;
        r.funct7 = f7;
        r.srcA = sa;
        r.srcB = sb;
        r.pcBase = base;
        r.pc = pc;
        r.rs1Data = rs1;
        r.rs2Data = rs2;
        r.imm = imm;
        return r;
    endfunction

    task automatic sendReq(input execPkg::execReqT req);
        @(negedge clk);
        while (credits == 0) begin  // hold off until a slot comes back
            inValid = 1'b0;
            @(negedge clk);
        end
        req.tag = tagSeq;
        tagSeq = tagSeq + 1'b1;
        inValid = 1'b1;
        inReq = req;
        credits--;
        expQ.push_back(refModel(req));
    endtask

    // reg-reg or reg-imm op with b on both rs2 and imm
    task automatic sendAlu(input execPkg::aluOpE op, input logic [2:0] f3, input logic [6:0] f7,
            input logic [31:0] a, input logic [31:0] b);
        execPkg::srcBE sb;
        sb = (op == execPkg::aluOpI) ? execPkg::srcBImm : execPkg::srcBReg;
        sendReq(mkReq(op, f3, f7, execPkg::srcAReg, sb, execPkg::pcBasePc, 32'h400, a, b, b));
    endtask

    task automatic sendBranch(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
        sendReq(mkReq(execPkg::aluOpBranch, f3, 7'h0, execPkg::srcAReg, execPkg::srcBReg,
                      execPkg::pcBasePc, 32'h1000 + {a[3:0], 2'b0}, a, b, 32'hffff_fff0 + b));
    endtask

    task automatic drain();
        @(negedge clk);
        inValid = 1'b0;
        while (expQ.size() != 0) @(negedge clk);
    endtask

    task automatic setGrantMode(input int mode);
        @(posedge clk);
        grantMode = mode;
    endtask

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want,
            input logic [`EXEC_TAG_W-1:0] tag);
        assert (got == want) else begin
            $display("** Error at %0t ns: %s of tag %0d is %h, expected %h",
                     $time, name, tag, got, want);
            errors++;
        end
    endtask

    task automatic reportTest(input string name);
        if (errors == errAtStart) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: FAILED with %0d errors", name, errors - errAtStart);
        end
        errAtStart = errors;
    endtask

    // response checker and producer credit return
    always @(posedge clk) begin
        if (outValid) begin
            resultsSeen++;
            assert (outCredits > 0) else begin
                $display("a result left while the consumer had granted no credit");
                errors++;
            end
            assert (expQ.size() != 0) else begin
                $display("a result arrived at %0t ns with no request pending", $time);
                errors++;
            end
            if (expQ.size() != 0) begin
                expHead = expQ.pop_front();
                checkField("tag", 32'(outResp.tag), 32'(expHead.tag), expHead.tag);
                checkField("result", outResp.result, expHead.result, expHead.tag);
                checkField("target", outResp.target, expHead.target, expHead.tag);
                checkField("taken", 32'(outResp.taken), 32'(expHead.taken), expHead.tag);
                checkField("isBranch", 32'(outResp.isBranch), 32'(expHead.isBranch), expHead.tag);
            end
        end
        assert (inCredit == outValid) else begin
            $display("input credit pulse at %0t ns does not match a leaving result", $time);
            errors++;
        end
        if (inCredit) credits++;
        outCredits += int'(outCredit) - int'(outValid);
    end

    // consumer with queue-depth slots
    always @(negedge clk) begin
        grantRnd = $random(grantSeed);
        outCredit = 1'b0;
        if (rstN && outCredits < `EXEC_QUEUE_DEPTH) begin
            case (grantMode)
                grantFree:   outCredit = 1'b1;
                grantRandom: outCredit = grantRnd[0];
                default: begin
                    if (manualGrants > 0) begin
                        outCredit = 1'b1;
                        manualGrants--;
                    end
                end
            endcase
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout: tests still running after %0d cycles", maxCycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic rTypeTest();
        setGrantMode(grantFree);
        sendAlu(execPkg::aluOpR, 3'd0, 7'h00, 32'h7fff_ffff, 32'h1);   // overflow into sign
        sendAlu(execPkg::aluOpR, 3'd0, 7'h20, 32'h8000_0000, 32'h1);
        sendAlu(execPkg::aluOpR, 3'd7, 7'h00, 32'hf0f0_1234, 32'h0ff0_ff00);
        sendAlu(execPkg::aluOpR, 3'd6, 7'h00, 32'hf0f0_1234, 32'h0ff0_ff00);
        sendAlu(execPkg::aluOpR, 3'd4, 7'h00, 32'hf0f0_1234, 32'h0ff0_ff00);
        sendAlu(execPkg::aluOpR, 3'd1, 7'h00, 32'h8000_0001, 32'h0);
        sendAlu(execPkg::aluOpR, 3'd1, 7'h00, 32'h0000_0003, 32'h1f);
        sendAlu(execPkg::aluOpR, 3'd5, 7'h00, 32'h8000_0000, 32'h1f);
        sendAlu(execPkg::aluOpR, 3'd5, 7'h20, 32'h8000_0000, 32'h1f);
        sendAlu(execPkg::aluOpR, 3'd5, 7'h20, 32'h8765_4321, 32'h0);
        sendAlu(execPkg::aluOpR, 3'd2, 7'h00, 32'h8000_0000, 32'h1);
        sendAlu(execPkg::aluOpR, 3'd3, 7'h00, 32'h8000_0000, 32'h1);
        drain();
        reportTest("r-type");
    endtask

    task automatic iTypeTest();
        sendAlu(execPkg::aluOpI, 3'd0, 7'h20, 32'h10, 32'hffff_fff0);  // no subi
        sendAlu(execPkg::aluOpI, 3'd2, 7'h00, 32'hffff_ffff, 32'h1);
        sendAlu(execPkg::aluOpI, 3'd3, 7'h00, 32'hffff_ffff, 32'h1);
        sendAlu(execPkg::aluOpI, 3'd4, 7'h00, 32'h5555_aaaa, 32'hffff_ffff);
        sendAlu(execPkg::aluOpI, 3'd6, 7'h00, 32'h1200_0000, 32'h0000_07ff);
        sendAlu(execPkg::aluOpI, 3'd7, 7'h00, 32'h1234_5678, 32'hffff_f800);
        sendAlu(execPkg::aluOpI, 3'd1, 7'h00, 32'h0000_00ff, 32'h4);
        sendAlu(execPkg::aluOpI, 3'd5, 7'h00, 32'hf000_0000, 32'h4);
        sendAlu(execPkg::aluOpI, 3'd5, 7'h20, 32'hf000_0000, 32'h4);
        drain();
        reportTest("i-type");
    endtask

    task automatic branchTest();
        sendBranch(3'd0, 32'h5, 32'h5);
        sendBranch(3'd0, 32'h5, 32'h6);
        sendBranch(3'd1, 32'h5, 32'h6);
        sendBranch(3'd1, 32'h5, 32'h5);
        sendBranch(3'd4, 32'hffff_ffff, 32'h1);   // -1 < 1 only when signed
        sendBranch(3'd4, 32'h1, 32'hffff_ffff);
        sendBranch(3'd5, 32'h1, 32'hffff_ffff);
        sendBranch(3'd5, 32'hffff_ffff, 32'h1);
        sendBranch(3'd6, 32'h1, 32'hffff_ffff);
        sendBranch(3'd6, 32'hffff_ffff, 32'h1);
        sendBranch(3'd7, 32'hffff_ffff, 32'h1);
        sendBranch(3'd7, 32'h1, 32'hffff_ffff);
        drain();
        reportTest("branch");
    endtask

    task automatic addrTest();
        sendReq(mkReq(execPkg::aluOpAddr, 3'd0, 7'h0, execPkg::srcAZero, execPkg::srcBImm,
                      execPkg::pcBasePc, 32'h2000, 32'h0, 32'h0, 32'h1234_5000));     // lui
        sendReq(mkReq(execPkg::aluOpAddr, 3'd0, 7'h0, execPkg::srcAPc, execPkg::srcBImm,
                      execPkg::pcBasePc, 32'h2004, 32'h0, 32'h0, 32'hfffff_000));    // auipc
        sendReq(mkReq(execPkg::aluOpAddr, 3'd0, 7'h0, execPkg::srcAPc, execPkg::srcBFour,
                      execPkg::pcBasePc, 32'h2008, 32'h0, 32'h0, 32'h0000_0100));    // jal
        sendReq(mkReq(execPkg::aluOpAddr, 3'd0, 7'h0, execPkg::srcAPc, execPkg::srcBFour,
                      execPkg::pcBaseReg, 32'h200c, 32'h3001, 32'h0, 32'hffff_fffc)); // jalr
        drain();
        reportTest("address forms");
    endtask

    task automatic backPressureTest();
        int seenBefore;
        int creditsBefore;
        setGrantMode(grantNone);
        seenBefore = resultsSeen;
        for (int i = 0; i < `EXEC_IN_CREDITS; i++) begin
            sendAlu(execPkg::aluOpR, 3'd0, 7'h00, 32'(i * 7), 32'h100);
        end
        @(negedge clk);
        inValid = 1'b0;
        repeat (12) @(negedge clk);
        assert (resultsSeen == seenBefore && credits == 0) else begin
            $display("a result or an input credit came back without any output credit");
            errors++;
        end
        for (int i = 0; i < `EXEC_IN_CREDITS; i++) begin
            creditsBefore = credits;
            @(posedge clk);
            manualGrants = 1;
            do @(negedge clk); while (resultsSeen == seenBefore + i);
            assert (credits == creditsBefore + 1) else begin
                $display("result %0d under back-pressure returned no input credit", i);
                errors++;
            end
        end
        drain();
        reportTest("back-pressure");
    endtask

    task automatic randomMixTest();
        execPkg::execReqT req;
        int rnd;
        setGrantMode(grantRandom);
        repeat (100) begin
            rnd = $random(seed);
            req = mkReq(execPkg::aluOpE'(rnd[1:0]), rnd[4:2], rnd[5] ? 7'h20 : 7'h00,
                        execPkg::srcAE'(2'(rnd[11:8] % 4'd3)),
                        execPkg::srcBE'(2'(rnd[15:12] % 4'd3)), execPkg::pcBaseE'(rnd[16]),
                        $random(seed), $random(seed), $random(seed), $random(seed));
            sendReq(req);
        end
        drain();
        assert (credits == `EXEC_IN_CREDITS) else begin
            $display("producer holds %0d credits after the random mix", credits);
            errors++;
        end
        reportTest("random mix");
    endtask

    initial begin
        seed = 64435;
        grantSeed = seed + 1;
        rstN = 1'b0;
        inValid = 1'b0;
        inReq = '0;
        outCredit = 1'b0;
        tagSeq = '0;
        credits = `EXEC_IN_CREDITS;
        outCredits = 0;
        grantMode = grantNone;
        manualGrants = 0;
        resultsSeen = 0;
        cycles = 0;
        errors = 0;
        errAtStart = 0;
        passCount = 0;
        failCount = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // runs while the DUT still holds no output credit
        backPressureTest();
        rTypeTest();
        iTypeTest();
        branchTest();
        addrTest();
        randomMixTest();
        $display("tests ok: %0d, tests failed: %0d", passCount, failCount);
        if (errors == 0 && failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- common/execPkg.sv
`include "exec_params.svh"

package execPkg;

    typedef enum logic [1:0] {
        aluOpR      = 2'd0,
        aluOpI      = 2'd1,
        aluOpBranch = 2'd2,
        aluOpAddr   = 2'd3  // lui, auipc, jal, jalr
    } aluOpE;

    typedef enum logic [1:0] {
        srcAReg  = 2'd0,
        srcAZero = 2'd1,
        srcAPc   = 2'd2
    } srcAE;

    typedef enum logic [1:0] {
        srcBReg  = 2'd0,
        srcBImm  = 2'd1,
        srcBFour = 2'd2
    } srcBE;

    // base operand of the jump/branch target adder
    typedef enum logic {
        pcBasePc  = 1'b0,
        pcBaseReg = 1'b1
    } pcBaseE;

    typedef enum logic [3:0] {
        ctrlAdd, ctrlSub, ctrlAnd, ctrlOr, ctrlXor,
        ctrlSll, ctrlSrl, ctrlSra, ctrlSlt, ctrlSltu
    } aluCtrlE;

    typedef enum logic [2:0] {
        condNone, condEq, condNe, condLt, condGe, condLtu, condGeu
    } brCondE;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  rs1Data;
        logic [`EXEC_XLEN-1:0]  rs2Data;
        logic [`EXEC_XLEN-1:0]  imm;
        aluOpE                  aluOp;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        srcAE                   srcA;
        srcBE                   srcB;
        pcBaseE                 pcBase;
        logic [`EXEC_TAG_W-1:0] tag;
    } execReqT;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  opA;
        logic [`EXEC_XLEN-1:0]  opB;
        logic [`EXEC_XLEN-1:0]  targetBase;
        logic [`EXEC_XLEN-1:0]  imm;
        aluCtrlE                ctrl;
        brCondE                 cond;
        logic [`EXEC_TAG_W-1:0] tag;
    } operandT;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  result;
        logic                   taken;
        logic [`EXEC_XLEN-1:0]  targetBase;
        logic [`EXEC_XLEN-1:0]  imm;
        logic                   isBranch;
        logic [`EXEC_TAG_W-1:0] tag;
    } aluResT;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  result;
        logic [`EXEC_XLEN-1:0]  target;
        logic                   taken;
        logic                   isBranch;
        logic [`EXEC_TAG_W-1:0] tag;
    } execRespT;

endpackage

//--- common/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath width
`define EXEC_XLEN 32

// request tag, carried through to the response
`define EXEC_TAG_W 4

// entries in the output queue of stage 3
`define EXEC_QUEUE_DEPTH 4

// producer credits after reset
// one per queue slot, so the pipeline itself never stalls
`define EXEC_IN_CREDITS `EXEC_QUEUE_DEPTH

`endif

//--- exec/alu.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module alu (
    input  logic             clk,
    input  logic             rstN,
    input  logic             opValid,
    input  execPkg::operandT opData,
    output logic             resValid,
    output execPkg::aluResT  resData
);

    logic [`EXEC_XLEN-1:0] opA;
    logic [`EXEC_XLEN-1:0] opB;
    logic [`EXEC_XLEN-1:0] shifted;
    logic [`EXEC_XLEN-1:0] result;
    logic                  dirRight;
    logic                  arith;
    logic                  taken;

    assign opA = opData.opA;
    assign opB = opData.opB;
    assign dirRight = (opData.ctrl == execPkg::ctrlSrl) || (opData.ctrl == execPkg::ctrlSra);
    assign arith = (opData.ctrl == execPkg::ctrlSra);

    shifter uShifter (
        .dirRight (dirRight),
        .arith    (arith),
        .value    (opA),
        .amount   (opB[4:0]),     // only the low five bits count
        .shifted  (shifted)
    );

    always_comb begin
        case (opData.ctrl)
            execPkg::ctrlAdd:  result = opA + opB;
            execPkg::ctrlSub:  result = opA - opB;
            execPkg::ctrlAnd:  result = opA & opB;
            execPkg::ctrlOr:   result = opA | opB;
            execPkg::ctrlXor:  result = opA ^ opB;
            execPkg::ctrlSlt:  result = {{(`EXEC_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            execPkg::ctrlSltu: result = {{(`EXEC_XLEN-1){1'b0}}, opA < opB};
            default:           result = shifted;
        endcase
    end

    // plain compares, no overflow trouble from the difference sign
    always_comb begin
        case (opData.cond)
            execPkg::condEq:  taken = (opA == opB);
            execPkg::condNe:  taken = (opA != opB);
            execPkg::condLt:  taken = $signed(opA) < $signed(opB);
            execPkg::condGe:  taken = $signed(opA) >= $signed(opB);
            execPkg::condLtu: taken = opA < opB;
            execPkg::condGeu: taken = opA >= opB;
            default:          taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= opValid;
        end
    end

    always_ff @(posedge clk) begin
        resData.result <= result;
        resData.taken <= taken;
        resData.targetBase <= opData.targetBase;
        resData.imm <= opData.imm;
        resData.isBranch <= (opData.cond != execPkg::condNone);
        resData.tag <= opData.tag;
    end

endmodule

//--- exec/branchResolve.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module branchResolve (
    input  logic              clk,
    input  logic              rstN,
    input  logic              resValid,
    input  execPkg::aluResT   resData,
    input  logic              outCredit,
    output logic              outValid,
    output execPkg::execRespT outResp,
    output logic              inCredit
);

    localparam int depth = `EXEC_QUEUE_DEPTH;
    localparam int ptrW = $clog2(depth);
    localparam int creditW = ptrW + 3;  // headroom for early grants

    execPkg::execRespT  queue [depth];
    execPkg::execRespT  entry;
    logic [ptrW-1:0]    wrPtr;
    logic [ptrW-1:0]    rdPtr;
    logic [ptrW:0]      count;
    logic [creditW-1:0] credits;     // downstream credits
    logic               pop;

    function automatic logic [ptrW-1:0] bump(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        entry.result = resData.result;
        entry.target = resData.targetBase + resData.imm;  // no jalr bit-0 clear
        entry.taken = resData.taken;
        entry.isBranch = resData.isBranch;
        entry.tag = resData.tag;
    end

    // head leaves whenever the consumer has room
    assign pop = (count != '0) && (credits != '0);
    assign outValid = pop;
    assign outResp = queue[rdPtr];
    assign inCredit = pop;  // slot freed, producer may send again

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            credits <= '0;
        end else begin
            if (resValid) begin
                wrPtr <= bump(wrPtr);
            end
            if (pop) begin
                rdPtr <= bump(rdPtr);
            end
            count <= count + (ptrW + 1)'(resValid) - (ptrW + 1)'(pop);
            credits <= credits + creditW'(outCredit) - creditW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (resValid) begin
            queue[wrPtr] <= entry;
        end
    end

    // input credits bound what is in flight, so a full queue sees no write
    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        resValid |-> (count < depth))
        else $error("write into a full output queue");

    // spending the last credit blocks the next cycle unless a grant arrives
    creditGate: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && credits == creditW'(1) && !outCredit) |=> !outValid)
        else $error("result sent without an output credit");

endmodule

//--- exec/operandSelect.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module operandSelect (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  execPkg::execReqT  inReq,
    output logic              opValid,
    output execPkg::operandT  opData
);

    logic                  altFunc;
    execPkg::aluCtrlE      ctrl;
    execPkg::brCondE       cond;
    execPkg::operandT      nextOp;

    assign altFunc = (inReq.funct7 == 7'b0100000);   // sub / sra flavour

    // control code from class, funct3 and funct7
    always_comb begin
        ctrl = execPkg::ctrlAdd;
        case (inReq.aluOp)
            execPkg::aluOpR, execPkg::aluOpI: begin
                case (inReq.funct3)
                    // there is no subi, so funct7 only counts for R
                    3'b000: ctrl = (altFunc && inReq.aluOp == execPkg::aluOpR) ?
                                   execPkg::ctrlSub : execPkg::ctrlAdd;
                    3'b001: ctrl = execPkg::ctrlSll;
                    3'b010: ctrl = execPkg::ctrlSlt;
                    3'b011: ctrl = execPkg::ctrlSltu;
                    3'b100: ctrl = execPkg::ctrlXor;
                    3'b101: ctrl = altFunc ? execPkg::ctrlSra : execPkg::ctrlSrl;
                    3'b110: ctrl = execPkg::ctrlOr;
                    default: ctrl = execPkg::ctrlAnd;
                endcase
            end
            execPkg::aluOpBranch: ctrl = execPkg::ctrlSub;
            default: ctrl = execPkg::ctrlAdd;   // address forms
        endcase
    end

    always_comb begin
        cond = execPkg::condNone;
        if (inReq.aluOp == execPkg::aluOpBranch) begin
            case (inReq.funct3)
                3'b000: cond = execPkg::condEq;
                3'b001: cond = execPkg::condNe;
                3'b100: cond = execPkg::condLt;
                3'b101: cond = execPkg::condGe;
                3'b110: cond = execPkg::condLtu;
                3'b111: cond = execPkg::condGeu;
                default: cond = execPkg::condNone;  // 010/011 are reserved
            endcase
        end
    end

    always_comb begin
        case (inReq.srcA)
            execPkg::srcAReg:  nextOp.opA = inReq.rs1Data;
            execPkg::srcAZero: nextOp.opA = '0;
            default:           nextOp.opA = inReq.pc;
        endcase
        case (inReq.srcB)
            execPkg::srcBReg: nextOp.opB = inReq.rs2Data;
            execPkg::srcBImm: nextOp.opB = inReq.imm;
            default:          nextOp.opB = `EXEC_XLEN'(4);    // link value for jal/jalr
        endcase
        nextOp.targetBase = (inReq.pcBase == execPkg::pcBaseReg) ? inReq.rs1Data : inReq.pc;
        nextOp.imm = inReq.imm;
        nextOp.ctrl = ctrl;
        nextOp.cond = cond;
        nextOp.tag = inReq.tag;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else begin
            opValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        opData <= nextOp;
    end

    // decode upstream must never hand over the spare select encoding
    srcLegal: assert property (@(posedge clk) disable iff (!rstN)
        inValid |-> (inReq.srcA inside {execPkg::srcAReg, execPkg::srcAZero, execPkg::srcAPc})
                 && (inReq.srcB inside {execPkg::srcBReg, execPkg::srcBImm, execPkg::srcBFour}))
        else $error("undefined operand select on a valid request");

endmodule

//--- exec/shifter.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module shifter (
    input  logic                  dirRight,
    input  logic                  arith,
    input  logic [`EXEC_XLEN-1:0] value,
    input  logic [4:0]            amount,
    output logic [`EXEC_XLEN-1:0] shifted
);

    logic [`EXEC_XLEN-1:0] level [0:5];
    logic                  fill;

    // left shifts run through the right shifter on the bit-reversed word
    assign level[0] = dirRight ? value : {<<{value}};
    assign fill = dirRight & arith & value[`EXEC_XLEN-1];

    genvar i;
    generate
        for (i = 0; i < 5; i++) begin : gLevel
            // shift by 2**i when this amount bit is set
            assign level[i+1] = amount[i] ?
                {{(1 << i){fill}}, level[i][`EXEC_XLEN-1:(1 << i)]} : level[i];
        end
    endgenerate

    assign shifted = dirRight ? level[5] : {<<{level[5]}};

endmodule

//--- project.f
+incdir+common
common/execPkg.sv
exec/operandSelect.sv
exec/shifter.sv
exec/alu.sv
exec/branchResolve.sv
verilog/execTop.sv
bench/execTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module execTb -f project.f -o execSim

out="$(./obj_dir/execSim)"
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- verilog/execTop.sv
`timescale 1ns/1ns

module execTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  execPkg::execReqT  inReq,
    output logic              inCredit,
    output logic              outValid,
    output execPkg::execRespT outResp,
    input  logic              outCredit
);

    logic             opValid;
    execPkg::operandT opData;
    logic             resValid;
    execPkg::aluResT  resData;

    // stage 1, operand select
    operandSelect uOperandSelect (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .inReq   (inReq),
        .opValid (opValid),
        .opData  (opData)
    );

    alu uAlu (
        .clk      (clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .opData   (opData),
        .resValid (resValid),
        .resData  (resData)
    );

    // stage 3, target adder and credit-gated output queue
    branchResolve uBranchResolve (
        .clk       (clk),
        .rstN      (rstN),
        .resValid  (resValid),
        .resData   (resData),
        .outCredit (outCredit),
        .outValid  (outValid),
        .outResp   (outResp),
        .inCredit  (inCredit)
    );

endmodule
